/* rtl/fetch_pkg.sv */
package fetch_pkg;

	// Cache geometry.
	localparam int index_bits = 6;
	localparam int line_count = 1 << index_bits;

	typedef logic [31:0] word_t;
	typedef logic [31:0] count_t;

	// Low bits of a tag word that mark the line as filled.
	localparam logic [1:0] tag_valid_code = 2'b01;

	// Data word sits above the tag word.
	typedef struct packed {
		word_t data;
		word_t tag;
	} cache_entry_t;

	typedef enum logic [1:0] {
		state_clear = 2'd0,
		state_idle = 2'd1,
		state_lookup = 2'd2,
		state_refill = 2'd3
	} fetch_state_t;

endpackage

/* rtl/miss_bus_if.sv */
`timescale 1ns/10ps

interface miss_bus_if;

	logic request;
	fetch_pkg::word_t address;
	logic ready;
	fetch_pkg::word_t rdata;

	modport controller (
		output request,
		output address,
		input ready,
		input rdata
	);

	modport master (
		input request,
		input address,
		output ready,
		output rdata
	);

endinterface

/* rtl/line_ram.sv */
`timescale 1ns/10ps

module line_ram (
	input logic i_clock,
	input logic i_write,
	input logic [fetch_pkg::index_bits-1:0] i_index,
	input fetch_pkg::cache_entry_t i_wdata,
	output fetch_pkg::cache_entry_t o_rdata
);

	fetch_pkg::cache_entry_t mem [fetch_pkg::line_count];

	// Reads first, so the old entry comes out on a write cycle.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			mem[i_index] <= i_wdata;
		end
		o_rdata <= mem[i_index];
	end

endmodule

/* rtl/icache_control.sv */
`timescale 1ns/10ps

module icache_control (
	input logic i_clock,
	input logic i_reset,
	input fetch_pkg::word_t i_pc,
	input logic i_stall,
	output logic o_ready,
	output fetch_pkg::word_t o_instruction,
	miss_bus_if.controller bus,
	output logic o_ram_write,
	output logic [fetch_pkg::index_bits-1:0] o_ram_index,
	output fetch_pkg::cache_entry_t o_ram_wdata,
	input fetch_pkg::cache_entry_t i_ram_rdata,
	output logic o_hit,
	output logic o_miss
);

	fetch_pkg::fetch_state_t state;
	fetch_pkg::fetch_state_t next_state;
	logic [fetch_pkg::index_bits-1:0] clear_index;
	fetch_pkg::word_t next_pc;
	fetch_pkg::word_t expected_tag;
	logic tag_match;

	assign next_pc = i_pc + 32'd4;
	assign expected_tag = {i_pc[31:2], fetch_pkg::tag_valid_code};
	assign tag_match = i_ram_rdata.tag == expected_tag;

	// The CPU holds i_pc until o_ready, so the address stays put for the whole refill.
	assign bus.request = state == fetch_pkg::state_refill;
	assign bus.address = i_pc;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_pkg::state_clear;
			clear_index <= '0;
		end else begin
			state <= next_state;
			if (state == fetch_pkg::state_clear) begin
				clear_index <= clear_index + 1'b1;
			end
		end
	end

	always_comb begin
		next_state = state;
		o_ready = 1'b0;
		o_instruction = i_ram_rdata.data;
		o_ram_write = 1'b0;
		o_ram_index = i_pc[fetch_pkg::index_bits+1:2];
		o_ram_wdata = '0;
		o_hit = 1'b0;
		o_miss = 1'b0;

		case (state)
			fetch_pkg::state_clear: begin
				// One line per cycle, all zeros.
				o_ram_write = 1'b1;
				o_ram_index = clear_index;
				if (&clear_index) begin
					next_state = fetch_pkg::state_idle;
				end
			end

			fetch_pkg::state_idle: begin
				if (!i_stall) begin
					next_state = fetch_pkg::state_lookup;
				end
			end

			fetch_pkg::state_lookup: begin
				if (i_stall) begin
					next_state = fetch_pkg::state_idle;
				end else if (tag_match) begin
					// Prefetch the next sequential line while this word goes out.
					o_ready = 1'b1;
					o_hit = 1'b1;
					o_ram_index = next_pc[fetch_pkg::index_bits+1:2];
				end else begin
					o_miss = 1'b1;
					next_state = fetch_pkg::state_refill;
				end
			end

			fetch_pkg::state_refill: begin
				o_instruction = bus.rdata;
				o_ram_wdata.data = bus.rdata;
				o_ram_wdata.tag = expected_tag;
				if (bus.ready) begin
					o_ram_write = 1'b1;
					// A stalled CPU picks the word up later as a hit.
					o_ready = !i_stall;
					next_state = fetch_pkg::state_idle;
				end
			end

			default: begin
				next_state = fetch_pkg::state_clear;
			end
		endcase
	end

	// Nothing is delivered before every line is cleared.
	no_ready_in_clear: assert property (@(posedge i_clock) disable iff (i_reset)
		state == fetch_pkg::state_clear |-> !o_ready);

	// Bus master only talks to us while a refill is pending.
	bus_only_in_refill: assert property (@(posedge i_clock) disable iff (i_reset)
		bus.ready |-> state == fetch_pkg::state_refill);

	hit_miss_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
		!(o_hit && o_miss));

endmodule

/* rtl/wb_fetch_master.sv */
`timescale 1ns/10ps

module wb_fetch_master (
	input logic i_clock,
	input logic i_reset,
	miss_bus_if.master bus,
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output fetch_pkg::word_t o_wb_adr,
	input fetch_pkg::word_t i_wb_dat,
	input logic i_wb_ack
);

	logic busy;
	fetch_pkg::word_t cycle_address;

	// A request seen while busy is the one being served, so it is not restarted.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
		end else if (busy) begin
			if (i_wb_ack) begin
				busy <= 1'b0;
			end
		end else if (bus.request) begin
			busy <= 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!busy && bus.request) begin
			cycle_address <= bus.address;
		end
	end

	assign o_wb_cyc = busy;
	assign o_wb_stb = busy;
	assign o_wb_adr = cycle_address;

	// Word passes straight through in the ack cycle.
	assign bus.ready = busy && i_wb_ack;
	assign bus.rdata = i_wb_dat;

	stb_within_cyc: assert property (@(posedge i_clock) disable iff (i_reset)
		o_wb_stb && !i_wb_ack |=> o_wb_stb && o_wb_cyc);

	// Slave may take its time, the address must not move meanwhile.
	adr_stable_until_ack: assert property (@(posedge i_clock) disable iff (i_reset)
		o_wb_stb && !i_wb_ack |=> $stable(o_wb_adr));

endmodule

/* rtl/fetch_stats.sv */
`timescale 1ns/10ps

module fetch_stats (
	input logic i_clock,
	input logic i_reset,
	input logic i_hit,
	input logic i_miss,
	output fetch_pkg::count_t o_hit_count,
	output fetch_pkg::count_t o_miss_count
);

	// Holds at all ones instead of wrapping.
	function automatic fetch_pkg::count_t saturate_inc(input fetch_pkg::count_t value);
		return (value == '1) ? value : value + 1'b1;
	endfunction

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_hit_count <= '0;
			o_miss_count <= '0;
		end else begin
			if (i_hit) begin
				o_hit_count <= saturate_inc(o_hit_count);
			end
			if (i_miss) begin
				o_miss_count <= saturate_inc(o_miss_count);
			end
		end
	end

endmodule

/* rtl/icache_top.sv */
`timescale 1ns/10ps

module icache_top (
	input logic i_clock,
	input logic i_reset,
	input fetch_pkg::word_t i_pc,
	input logic i_stall,
	output logic o_ready,
	output fetch_pkg::word_t o_instruction,
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output fetch_pkg::word_t o_wb_adr,
	input fetch_pkg::word_t i_wb_dat,
	input logic i_wb_ack,
	output fetch_pkg::count_t o_hit_count,
	output fetch_pkg::count_t o_miss_count
);

	miss_bus_if miss_bus ();

	logic ram_write;
	logic [fetch_pkg::index_bits-1:0] ram_index;
	fetch_pkg::cache_entry_t ram_wdata;
	fetch_pkg::cache_entry_t ram_rdata;
	logic hit;
	logic miss;

	icache_control i_icache_control (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(i_pc),
		.i_stall(i_stall),
		.o_ready(o_ready),
		.o_instruction(o_instruction),
		.bus(miss_bus.controller),
		.o_ram_write(ram_write),
		.o_ram_index(ram_index),
		.o_ram_wdata(ram_wdata),
		.i_ram_rdata(ram_rdata),
		.o_hit(hit),
		.o_miss(miss)
	);

	line_ram i_line_ram (
		.i_clock(i_clock),
		.i_write(ram_write),
		.i_index(ram_index),
		.i_wdata(ram_wdata),
		.o_rdata(ram_rdata)
	);

	wb_fetch_master i_wb_fetch_master (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.bus(miss_bus.master),
		.o_wb_cyc(o_wb_cyc),
		.o_wb_stb(o_wb_stb),
		.o_wb_adr(o_wb_adr),
		.i_wb_dat(i_wb_dat),
		.i_wb_ack(i_wb_ack)
	);

	fetch_stats i_fetch_stats (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_hit(hit),
		.i_miss(miss),
		.o_hit_count(o_hit_count),
		.o_miss_count(o_miss_count)
	);

endmodule

/* verification/wb_memory_model.sv */
`timescale 1ns/10ps

module wb_memory_model (
	input logic i_clock,
	input logic i_reset,
	input logic i_wb_cyc,
	input logic i_wb_stb,
	input fetch_pkg::word_t i_wb_adr,
	output fetch_pkg::word_t o_wb_dat,
	output logic o_wb_ack
);

	logic [31:0] random_state;
	logic waiting;
	logic [1:0] wait_left;

	function automatic logic [31:0] lcg_step(input logic [31:0] value);
		return value * 32'd1664525 + 32'd1013904223;
	endfunction

	// Contents follow from the address alone.
	function automatic fetch_pkg::word_t memory_contents(input fetch_pkg::word_t addr);
		return (addr * 32'h9E37_79B1) ^ 32'hA5C3_0F96;
	endfunction

	always @(posedge i_clock) begin
		if (i_reset) begin
			random_state <= 32'd56249;
			o_wb_dat <= '0;
			o_wb_ack <= 1'b0;
			waiting <= 1'b0;
			wait_left <= '0;
		end else if (o_wb_ack) begin
			// Ack lasts one cycle, the master drops the cycle with it.
			o_wb_ack <= 1'b0;
		end else if (i_wb_cyc && i_wb_stb) begin
			if (!waiting) begin
				random_state <= lcg_step(random_state);
				wait_left <= random_state[17:16];
				waiting <= 1'b1;
			end else if (wait_left == 2'd0) begin
				o_wb_dat <= memory_contents(i_wb_adr);
				o_wb_ack <= 1'b1;
				waiting <= 1'b0;
			end else begin
				wait_left <= wait_left - 2'd1;
			end
		end
	end

endmodule

/* verification/icache_tb.sv */
`timescale 1ns/10ps

module icache_tb;

	localparam int pass_words = 32;
	localparam int max_fetches = 2 * pass_words + 2 + 8 * 6;
	localparam int watchdog_cycles = fetch_pkg::line_count + max_fetches * 8 + 100;
	localparam fetch_pkg::word_t base_pc = 32'h0000_0100;

	logic clock = 1'b0;
	logic reset;
	fetch_pkg::word_t pc;
	logic stall;
	logic ready;
	fetch_pkg::word_t instruction;
	logic wb_cyc;
	logic wb_stb;
	fetch_pkg::word_t wb_adr;
	fetch_pkg::word_t wb_dat;
	logic wb_ack;
	fetch_pkg::count_t hit_count;
	fetch_pkg::count_t miss_count;

	// Direct-mapped tag array model.
	fetch_pkg::word_t tag_model [fetch_pkg::line_count];
	logic tag_filled [fetch_pkg::line_count];
	int expected_hits = 0;
	int expected_misses = 0;
	int wb_starts = 0;
	int last_cycles = 0;
	logic last_predicted_hit = 1'b0;
	logic prev_cyc = 1'b0;
	logic [31:0] random_state = 32'd56249;

	always #5 clock = ~clock;

	icache_top i_icache_top (
		.i_clock(clock),
		.i_reset(reset),
		.i_pc(pc),
		.i_stall(stall),
		.o_ready(ready),
		.o_instruction(instruction),
		.o_wb_cyc(wb_cyc),
		.o_wb_stb(wb_stb),
		.o_wb_adr(wb_adr),
		.i_wb_dat(wb_dat),
		.i_wb_ack(wb_ack),
		.o_hit_count(hit_count),
		.o_miss_count(miss_count)
	);

	wb_memory_model i_wb_memory_model (
		.i_clock(clock),
		.i_reset(reset),
		.i_wb_cyc(wb_cyc),
		.i_wb_stb(wb_stb),
		.i_wb_adr(wb_adr),
		.o_wb_dat(wb_dat),
		.o_wb_ack(wb_ack)
	);

	function automatic fetch_pkg::word_t mem_word(input fetch_pkg::word_t addr);
		return (addr * 32'h9E37_79B1) ^ 32'hA5C3_0F96;
	endfunction

	function automatic logic [31:0] lcg_step(input logic [31:0] value);
		return value * 32'd1664525 + 32'd1013904223;
	endfunction

	function int draw_below(input int limit);
		random_state = lcg_step(random_state);
		return int'(random_state[30:16]) % limit;
	endfunction

	function automatic int line_of(input fetch_pkg::word_t addr);
		return int'((addr >> 2) % fetch_pkg::line_count);
	endfunction

	task automatic report_failure(input string line);
		$display("%s", line);
		$display("Verification failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_word(input fetch_pkg::word_t actual, input fetch_pkg::word_t expected,
			input string what);
		if (actual !== expected) begin
			report_failure($sformatf("FAILED at %0t: %s is %h, expected %h",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_count(input fetch_pkg::count_t actual,
			input fetch_pkg::count_t expected, input string what);
		if (actual !== expected) begin
			report_failure($sformatf("FAILED at %0t: %s is %0d, expected %0d",
				$time, what, actual, expected));
		end
	endtask

	task automatic check_flag(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			report_failure($sformatf("FAILED at %0t: %s is %b, expected %b",
				$time, what, actual, expected));
		end
	endtask

	// Drive one cycle on the rising edge, look at the outputs at the falling edge.
	task automatic run_cycle(input fetch_pkg::word_t next_pc, input logic next_stall);
		@(posedge clock);
		pc <= next_pc;
		stall <= next_stall;
		@(negedge clock);
		check_flag(ready && stall, 1'b0, "o_ready while stalled");
		if (wb_cyc && !prev_cyc) begin
			wb_starts++;
			check_word(wb_adr, pc, "Wishbone address");
		end
		// A word refilled under stall is delivered later as a hit.
		if (wb_cyc && wb_ack && stall) begin
			expected_hits++;
		end
		prev_cyc = wb_cyc;
	endtask

	task automatic fetch_word(input fetch_pkg::word_t addr, input logic bubble,
			input int stall_percent);
		int starts_before;
		int line;
		logic next_stall;
		starts_before = wb_starts;
		line = line_of(addr);
		last_predicted_hit = tag_filled[line] && tag_model[line] == addr;
		last_cycles = 0;
		next_stall = bubble || (draw_below(100) < stall_percent);
		do begin
			run_cycle(addr, next_stall);
			next_stall = draw_below(100) < stall_percent;
			last_cycles++;
		end while (!ready);
		check_word(instruction, mem_word(addr), "instruction");
		check_count(wb_starts - starts_before, last_predicted_hit ? 0 : 1,
			"Wishbone cycles for one fetch");
		if (last_predicted_hit) begin
			expected_hits++;
		end else begin
			expected_misses++;
		end
		tag_model[line] = addr;
		tag_filled[line] = 1'b1;
	endtask

	initial begin
		fetch_pkg::word_t start;
		int length;
		for (int i = 0; i < fetch_pkg::line_count; i++) begin
			tag_filled[i] = 1'b0;
		end
		reset = 1'b1;
		pc = '0;
		stall = 1'b0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		// Clear runs one line per cycle.
		repeat (fetch_pkg::line_count) begin
			@(negedge clock);
			check_flag(ready, 1'b0, "o_ready during clear");
			check_flag(wb_cyc, 1'b0, "o_wb_cyc during clear");
			check_flag(wb_stb, 1'b0, "o_wb_stb during clear");
			check_count(hit_count, 0, "hit count during clear");
			check_count(miss_count, 0, "miss count during clear");
		end
		for (int i = 0; i < pass_words; i++) begin
			fetch_word(base_pc + 4 * i, i == 0, 0);
		end
		check_count(wb_starts, pass_words, "Wishbone cycles in the first pass");
		// Second pass streams from the cache.
		for (int i = 0; i < pass_words; i++) begin
			fetch_word(base_pc + 4 * i, i == 0, 0);
			if (i > 0) begin
				check_count(last_cycles, 1, "cycles between sequential hits");
			end
		end
		check_count(wb_starts, pass_words, "Wishbone cycles after the second pass");
		fetch_word(base_pc + 4 * fetch_pkg::line_count, 1'b1, 0);
		check_count(miss_count, expected_misses, "miss count after the conflict fetch");
		fetch_word(base_pc, 1'b1, 0);
		check_count(miss_count, expected_misses, "miss count after the evicted word");
		// Jumps take one bubble cycle.
		for (int run = 0; run < 8; run++) begin
			start = 4 * draw_below(256);
			length = 1 + draw_below(6);
			for (int k = 0; k < length; k++) begin
				fetch_word(start + 4 * k, k == 0, 30);
			end
		end
		@(posedge clock);
		stall <= 1'b1;
		@(negedge clock);
		check_count(hit_count, expected_hits, "hit count");
		check_count(miss_count, expected_misses, "miss count");
		$display("Verification passed");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		report_failure("Watchdog expired before all fetches were delivered");
	end

endmodule

/* verilog.f */
rtl/fetch_pkg.sv
rtl/miss_bus_if.sv
rtl/line_ram.sv
rtl/icache_control.sv
rtl/wb_fetch_master.sv
rtl/fetch_stats.sv
rtl/icache_top.sv
verification/wb_memory_model.sv
verification/icache_tb.sv

/* Makefile */
.PHONY: all lint clean

all: obj_dir/Vicache_tb
	-./obj_dir/Vicache_tb > sim.log 2>&1
	cat sim.log
	! grep -q "Verification failed" sim.log
	grep -q "Verification passed" sim.log

obj_dir/Vicache_tb: verilog.f rtl/*.sv verification/*.sv
	verilator --binary --timing --assert -j 0 --top-module icache_tb -f verilog.f

lint:
	verilator --lint-only -Wall --timing --top-module icache_top -f verilog.f

clean:
	rm -rf obj_dir sim.log
